// ==== include/xcvr_reset_defs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// count of transceiver status lines, must match xcvr_status_t
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef XCVR_RESET_DEFS_SVH
`define XCVR_RESET_DEFS_SVH

// pll_locked, oc_busy, locked_to_data
`define n_status_lines 3

`endif

// ==== verilog/xcvr_reset_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timers assume a 125 MHz clk, full length in sim too
// struct field order must follow the channel wiring
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "xcvr_reset_defs.svh"

package xcvr_reset_pkg;

	localparam int clk_mhz              = 125;            // system clock
	localparam int digital_pulse_cycles = 3;              // pcs-only reset pulse
	localparam int settle_cycles        = 2;              // after tx digital / rx analog
	localparam int ltd_settle_cycles    = clk_mhz * 4;    // 4 us of cdr lock to data
	localparam int sync_stages          = 2;              // synchroniser depth
	localparam int status_bits          = `n_status_lines;

	// asynchronous status from the channel
	typedef struct packed {
		logic pll_locked;      // tx pll locked
		logic oc_busy;         // rx offset cancellation running
		logic locked_to_data;  // rx cdr locked to data
	} xcvr_status_t;

	// resets driven into the channel, all active high
	typedef struct packed {
		logic tx_digital;  // tx pcs
		logic rx_analog;   // rx pma
		logic rx_digital;  // rx pcs
	} xcvr_resets_t;

	// pessimistic view of the channel until the synchroniser has filled
	localparam xcvr_status_t status_safe = '{pll_locked: 1'b0, oc_busy: 1'b1,
		locked_to_data: 1'b0};

	typedef enum logic [1:0] {st_hold, st_wait_done, st_settle, st_done} stage_state_t;

endpackage

`default_nettype wire

// ==== verilog/reset_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// start is a level, stage holds while it is high
// hold_til_done=0: fixed pulse, done_in ignored
// hold_til_done=1: release on done_in, done after settle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module reset_stage #(
	parameter int hold_cycles   = 0,  // extra hold cycles once start falls (fixed mode)
	parameter bit hold_til_done = 1,  // 1: keep reset until done_in seen
	parameter int settle_delay  = 2   // cycles of done_in high before seq_done
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic done_in,
	output logic stage_reset,
	output logic seq_done
);
	import xcvr_reset_pkg::*;

	// one counter covers both the hold and the settle phase
	localparam int cnt_max = (hold_cycles > settle_delay) ? hold_cycles : settle_delay;
	localparam int cnt_w   = (cnt_max < 2) ? 1 : $clog2(cnt_max + 1);

	stage_state_t     state;
	logic [cnt_w-1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset || start) begin
			state       <= st_hold;
			cnt         <= cnt_w'(hold_cycles);  // preload the fixed hold
			stage_reset <= 1'b1;
			seq_done    <= 1'b0;
		end else begin
			case (state)
				st_hold: begin
					if (hold_til_done) begin
						state <= st_wait_done;  // reset stays on
					end else if (cnt <= cnt_w'(1)) begin
						// fixed pulse over, release and report together
						state       <= st_done;
						stage_reset <= 1'b0;
						seq_done    <= 1'b1;
					end else begin
						cnt <= cnt - cnt_w'(1);
					end
				end
				st_wait_done: begin
					if (done_in) begin
						state       <= st_settle;
						stage_reset <= 1'b0;  // released on first sight of done
						cnt         <= cnt_w'(settle_delay);
					end
				end
				st_settle: begin
					if (!done_in) begin
						// condition lost, back to holding
						state       <= st_wait_done;
						stage_reset <= 1'b1;
					end else if (cnt <= cnt_w'(1)) begin
						state    <= st_done;
						seq_done <= 1'b1;
					end else begin
						cnt <= cnt - cnt_w'(1);
					end
				end
				st_done: begin
					state <= st_done;  // sticky until start
				end
				default: begin
					state       <= st_hold;
					stage_reset <= 1'b1;
					seq_done    <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/status_sync.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// each status bit is synchronised on its own
// latency is sync_stages cycles, reset gives the safe values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module status_sync (
	input  logic                        clk,
	input  logic                        reset,
	input  xcvr_reset_pkg::xcvr_status_t status_raw,  // asynchronous to clk
	output xcvr_reset_pkg::xcvr_status_t status
);
	import xcvr_reset_pkg::*;

	logic [status_bits-1:0] sync_q [sync_stages];  // [0] is the metastable flop

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < sync_stages; i++) begin
				sync_q[i] <= status_bits'(status_safe);  // pll unlocked, oc busy
			end
		end else begin
			sync_q[0] <= status_raw;
			for (int i = 1; i < sync_stages; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// a lock only shows once it has passed the whole chain
	assign status = xcvr_status_t'(sync_q[sync_stages-1]);

endmodule

`default_nettype wire

// ==== verilog/channel_reset_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// status must already be synchronous to clk
// order: tx digital, rx analog, rx digital
// digital-only requests pulse the pcs resets only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module channel_reset_ctrl (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         reset_all,
	input  logic                         reset_tx_digital,
	input  logic                         reset_rx_digital,
	input  xcvr_reset_pkg::xcvr_status_t status,
	output xcvr_reset_pkg::xcvr_resets_t resets,
	output logic                         tx_ready,
	output logic                         rx_ready
);
	import xcvr_reset_pkg::*;

	logic seq_start, tx_pulse_start, rx_pulse_start;
	logic tx_dig_reset, tx_dig_done;
	logic rx_ana_reset, rx_ana_done;
	logic rx_dig_reset, rx_dig_done;
	logic tx_pulse_reset, tx_pulse_done;
	logic rx_pulse_reset, rx_pulse_done;

	assign seq_start      = reset | reset_all;               // full sequence restart
	assign tx_pulse_start = seq_start | reset_tx_digital;
	assign rx_pulse_start = seq_start | reset_rx_digital;

	// tx pcs waits for the pll
	reset_stage #(.hold_cycles(0), .hold_til_done(1'b1), .settle_delay(settle_cycles))
	tx_dig_i (
		.clk(clk), .reset(reset), .start(seq_start),
		.done_in(status.pll_locked),
		.stage_reset(tx_dig_reset), .seq_done(tx_dig_done)
	);

	// rx pma waits for tx and for offset cancellation to go idle
	reset_stage #(.hold_cycles(0), .hold_til_done(1'b1), .settle_delay(settle_cycles))
	rx_ana_i (
		.clk(clk), .reset(reset), .start(seq_start),
		.done_in(tx_dig_done & ~status.oc_busy),
		.stage_reset(rx_ana_reset), .seq_done(rx_ana_done)
	);

	// rx pcs needs 4 us of cdr lock to data
	reset_stage #(.hold_cycles(0), .hold_til_done(1'b1), .settle_delay(ltd_settle_cycles))
	rx_dig_i (
		.clk(clk), .reset(reset), .start(seq_start),
		.done_in(rx_ana_done & status.locked_to_data),
		.stage_reset(rx_dig_reset), .seq_done(rx_dig_done)
	);

	// fixed pulses, done_in has no meaning here
	reset_stage #(.hold_cycles(digital_pulse_cycles), .hold_til_done(1'b0), .settle_delay(0))
	tx_pulse_i (
		.clk(clk), .reset(reset), .start(tx_pulse_start), .done_in(1'b0),
		.stage_reset(tx_pulse_reset), .seq_done(tx_pulse_done)
	);

	reset_stage #(.hold_cycles(digital_pulse_cycles), .hold_til_done(1'b0), .settle_delay(0))
	rx_pulse_i (
		.clk(clk), .reset(reset), .start(rx_pulse_start), .done_in(1'b0),
		.stage_reset(rx_pulse_reset), .seq_done(rx_pulse_done)
	);

	assign resets.tx_digital = tx_dig_reset | tx_pulse_reset;  // sequence or pulse
	assign resets.rx_analog  = rx_ana_reset;
	assign resets.rx_digital = rx_dig_reset | rx_pulse_reset;

	assign tx_ready = tx_pulse_done & tx_dig_done;
	assign rx_ready = rx_pulse_done & rx_dig_done;

endmodule

`default_nettype wire

// ==== verilog/xcvr_reset_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single channel, status_raw may be asynchronous
// no pll or quad power-down outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xcvr_reset_top (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         reset_all,         // level, restarts sequence
	input  logic                         reset_tx_digital,  // level, tx pcs pulse
	input  logic                         reset_rx_digital,  // level, rx pcs pulse
	input  xcvr_reset_pkg::xcvr_status_t status_raw,
	output xcvr_reset_pkg::xcvr_resets_t resets,
	output logic                         tx_ready,
	output logic                         rx_ready
);
	import xcvr_reset_pkg::*;

	xcvr_status_t status;  // synchronised copy of status_raw

	status_sync status_sync_i (
		.clk        (clk),
		.reset      (reset),
		.status_raw (status_raw),
		.status     (status)
	);

	channel_reset_ctrl channel_reset_ctrl_i (
		.clk              (clk),
		.reset            (reset),
		.reset_all        (reset_all),
		.reset_tx_digital (reset_tx_digital),
		.reset_rx_digital (reset_rx_digital),
		.status           (status),
		.resets           (resets),
		.tx_ready         (tx_ready),
		.rx_ready         (rx_ready)
	);

endmodule

`default_nettype wire

// ==== sim/xcvr_reset_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into channel_reset_ctrl, uses its stage resets
// checks are off while reset is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xcvr_reset_assert (
	input logic                         clk,
	input logic                         reset,
	input logic                         tx_dig_reset,  // sequenced tx pcs reset only
	input logic                         rx_ana_reset,
	input xcvr_reset_pkg::xcvr_resets_t resets,
	input logic                         tx_ready,
	input logic                         rx_ready
);

	int n_fail = 0;  // count of failed properties

	// rx pma comes out only after the tx pcs sequence
	rx_ana_order: assert property (@(posedge clk) disable iff (reset)
		rx_ana_reset || !tx_dig_reset)
		else begin
			n_fail++;
			$error("rx analog released while tx digital still held by the sequence");
		end

	rx_dig_order: assert property (@(posedge clk) disable iff (reset)
		resets.rx_digital || !resets.rx_analog)
		else begin
			n_fail++;
			$error("rx digital released while rx analog still held");
		end

	// a tx pcs pulse may run under rx_ready, so only rx resets count
	rx_ready_clean: assert property (@(posedge clk) disable iff (reset)
		!rx_ready || (!resets.rx_analog && !resets.rx_digital))
		else begin
			n_fail++;
			$error("rx_ready high while an rx reset is active");
		end

	tx_ready_clean: assert property (@(posedge clk) disable iff (reset)
		!tx_ready || !resets.tx_digital)
		else begin
			n_fail++;
			$error("tx_ready high while tx digital reset is active");
		end

endmodule

`default_nettype wire

// ==== sim/tb_xcvr_reset.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run from the project root, steps come from sim/xcvr_reset_golden.txt
// stops at the first mismatch, ltd timer runs its full 500 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "xcvr_reset_defs.svh"

module tb_xcvr_reset;
	import xcvr_reset_pkg::*;

	localparam int step_max      = 128;  // room in the step memory
	localparam int reset_cycles  = 10;
	localparam int margin_cycles = 200;  // slack on top of all waits

	logic         clk = 1'b0;
	logic         reset;
	logic         reset_all;
	logic         reset_tx_digital;
	logic         reset_rx_digital;
	xcvr_status_t status_raw;
	xcvr_resets_t resets;
	logic         tx_ready;
	logic         rx_ready;

	logic [31:0] steps [step_max];  // op in [31:28], one field per hex digit below
	int          timeout_limit = reset_cycles + margin_cycles;
	int          cycle_count   = 0;
	int          n_checks      = 0;

	always #4 clk = ~clk;  // 8 ns period

	xcvr_reset_top dut_i (
		.clk              (clk),
		.reset            (reset),
		.reset_all        (reset_all),
		.reset_tx_digital (reset_tx_digital),
		.reset_rx_digital (reset_rx_digital),
		.status_raw       (status_raw),
		.resets           (resets),
		.tx_ready         (tx_ready),
		.rx_ready         (rx_ready)
	);

	bind channel_reset_ctrl xcvr_reset_assert assert_i (
		.clk(clk), .reset(reset), .tx_dig_reset(tx_dig_reset), .rx_ana_reset(rx_ana_reset),
		.resets(resets), .tx_ready(tx_ready), .rx_ready(rx_ready)
	);

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_resets(input xcvr_resets_t got, input xcvr_resets_t exp, input int step);
		n_checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: step %0d resets (tx_dig rx_ana rx_dig) got %b exp %b",
				$time, step, got, exp);
			abort_run();
		end
	endtask

	task automatic check_ready(input logic [1:0] got, input logic [1:0] exp, input int step);
		n_checks++;
		if (got !== exp) begin  // {tx_ready, rx_ready}
			$display("CHECK FAILED at %0t: step %0d tx_ready/rx_ready got %b exp %b",
				$time, step, got, exp);
			abort_run();
		end
	endtask

	// set digits: reset_all req_tx req_rx pll oc ltd
	task automatic apply_inputs(input logic [31:0] w);
		reset_all                 = w[20];
		reset_tx_digital          = w[16];
		reset_rx_digital          = w[12];
		status_raw.pll_locked     = w[8];
		status_raw.oc_busy        = w[4];
		status_raw.locked_to_data = w[0];
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;  // back to the drive point after the edge
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("timeout: golden steps still running after %0d cycles", cycle_count);
			abort_run();
		end
		if (dut_i.channel_reset_ctrl_i.assert_i.n_fail != 0) begin
			$display("a reset ordering assertion failed, see the error above");
			abort_run();
		end
	end

	initial begin : run_steps
		logic [3:0]   op;
		xcvr_resets_t exp_resets;
		logic [1:0]   exp_ready;
		int           last;

		reset            = 1'b1;
		reset_all        = 1'b0;
		reset_tx_digital = 1'b0;
		reset_rx_digital = 1'b0;
		status_raw       = '{pll_locked: 1'b0, oc_busy: 1'b1, locked_to_data: 1'b0};

		if ($bits(xcvr_status_t) != `n_status_lines) begin
			$display("status struct width does not match the status line count");
			abort_run();
		end

		// find the end marker and add up the waits for the timeout
		$readmemh("sim/xcvr_reset_golden.txt", steps);
		last = -1;
		for (int i = 0; i < step_max && last < 0; i++) begin
			op = steps[i][31:28];
			if (op == 4'hf) begin
				last = i;
			end else if (op == 4'h2) begin
				timeout_limit += int'(steps[i][15:0]);
			end else if (op != 4'h1 && op != 4'h3) begin
				$display("golden step %0d has an unknown kind or the end marker is missing", i);
				abort_run();
			end
		end
		if (last < 0) begin
			$display("golden file has no end marker");
			abort_run();
		end

		repeat (reset_cycles) @(posedge clk);
		#1 reset = 1'b0;

		for (int i = 0; i < last; i++) begin
			op = steps[i][31:28];
			case (op)
				4'h1: apply_inputs(steps[i]);
				4'h2: wait_cycles(int'(steps[i][15:0]));
				default: begin  // expect
					exp_resets = '{tx_digital: steps[i][16], rx_analog: steps[i][12],
						rx_digital: steps[i][8]};
					exp_ready  = {steps[i][4], steps[i][0]};
					check_resets(resets, exp_resets, i);
					check_ready({tx_ready, rx_ready}, exp_ready, i);
				end
			endcase
		end

		$display("%0d checks over %0d golden steps", n_checks, last);
		if (dut_i.channel_reset_ctrl_i.assert_i.n_fail == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("a reset ordering assertion failed in the last cycle");
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
verilog/xcvr_reset_pkg.sv
verilog/reset_stage.sv
verilog/status_sync.sv
verilog/channel_reset_ctrl.sv
verilog/xcvr_reset_top.sv
sim/xcvr_reset_assert.sv
sim/tb_xcvr_reset.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs tb_xcvr_reset with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_xcvr_reset -o tb_xcvr_reset
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_xcvr_reset)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

// ==== sim/xcvr_reset_golden.txt ====
// op digit: 1 set, 2 wait, 3 expect, f end; set digits: reset_all req_tx req_rx pll oc ltd
// wait: cycle count in hex in the low 16 bits; expect digits: tx_dig rx_ana rx_dig tx_rdy rx_rdy
// after reset, pll unlocked
10000010
20000014
30011100
// pll locks, offset cancellation still busy
10000110
2000000a
30001110
// oc idle and cdr locked, ltd settle runs 500 cycles
10000101
20000004
30000110
200000f6
30000010
2000010a
30000011
// tx pcs only request
10010101
20000002
30010001
10000101
20000002
30010001
20000003
30000011
// rx pcs only request
10001101
20000002
30000110
10000101
20000002
30000110
20000003
30000011
// full restart with status good
10100101
20000003
30011100
10000101
20000005
30000110
20000005
30000010
// lock to data lost during rx digital settle, then full settle again
10000100
20000005
30000110
10000101
200001f4
30000010
2000000a
30000011
f0000000
